// File: audio_pkg.sv
package audio_pkg;

    //------------------------------------------------
    // I2S timing

    localparam int BCLK_DIV   = 4;                   // clk cycles per half bit clock
    localparam int SLOT_BITS  = 32;                  // Bit clocks per channel slot
    localparam int FRAME_BITS = 2 * SLOT_BITS;       // Left and right slot
    localparam int DIV_W      = $clog2(BCLK_DIV);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    //------------------------------------------------
    // Sample formats and gain

    localparam int MIC_BITS   = 24;
    localparam int SOUND_BITS = 16;
    localparam int GAIN_SHIFT = 12;
    localparam int PROD_W     = MIC_BITS + 9;        // Sample times signed 9-bit gain
    localparam int SOUND_MAX  = 2 ** (SOUND_BITS - 1) - 1;
    localparam int SOUND_MIN  = -(2 ** (SOUND_BITS - 1));

    localparam logic [7:0] GAIN_RESET = 8'd16;       // Passes top 16 bits of the mic word

    //------------------------------------------------
    // Register map, word addresses

    localparam logic [3:0] ADDR_CTRL  = 4'd0;
    localparam logic [3:0] ADDR_PEAK  = 4'd1;
    localparam logic [3:0] ADDR_COUNT = 4'd2;

    //------------------------------------------------
    // Shared structs

    typedef struct packed {
        logic                       valid;
        logic signed [MIC_BITS-1:0] data;
    } mic_stream_t;

    typedef struct packed {
        logic                         valid;
        logic signed [SOUND_BITS-1:0] data;
    } sound_stream_t;

    // Field order matches bits 8:0 of the CTRL register
    typedef struct packed {
        logic       mute;
        logic [7:0] gain;
    } audio_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } wb_rsp_t;

    typedef struct packed {
        logic ws;
        logic sck;
    } mic_pins_t;

    typedef struct packed {
        logic mclk;
        logic bclk;
        logic lrclk;
        logic sdata;
    } i2s_out_pins_t;

endpackage

// File: i2s_mic_receiver.sv
module i2s_mic_receiver
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output mic_pins_t   pins,
    output mic_stream_t sample
);

    logic [DIV_W-1:0]    div_cnt;
    logic                div_tick;
    logic                sck_q;
    logic                sck_rise;
    logic                sck_fall;
    logic [BIT_W-1:0]    bit_cnt;
    logic [BIT_W-1:0]    bit_next;
    logic                ws_q;
    logic                in_data;
    logic                last_bit;
    logic [MIC_BITS-1:0] shreg;
    logic                valid_q;
    logic [MIC_BITS-1:0] data_q;

    //------------------------------------------------
    // Bit clock and word select

    assign div_tick = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign sck_rise = div_tick && !sck_q;
    assign sck_fall = div_tick &&  sck_q;

    assign bit_next = (bit_cnt == BIT_W'(FRAME_BITS - 1)) ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck_q   <= 1'b0;
            bit_cnt <= '0;
            ws_q    <= 1'b0;
        end else begin
            if (div_tick) begin
                div_cnt <= '0;
                sck_q   <= ~sck_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall) begin                       // Slot position moves on falling sck
                bit_cnt <= bit_next;
                ws_q    <= (bit_next >= BIT_W'(SLOT_BITS));  // High in right slot
            end
        end
    end

    //------------------------------------------------
    // Deserializer

    // Data occupies bit clocks 1 to 24 of the left slot
    assign in_data  = sck_rise && (bit_cnt != '0) && (bit_cnt <= BIT_W'(MIC_BITS));
    assign last_bit = in_data && (bit_cnt == BIT_W'(MIC_BITS));

    always_ff @(posedge clk) begin
        if (in_data) begin
            shreg <= {shreg[MIC_BITS-2:0], sd};          // MSB first
        end
        if (last_bit) begin
            data_q <= {shreg[MIC_BITS-2:0], sd};         // Includes the LSB just sampled
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= last_bit;                         // One pulse per frame
        end
    end

    assign pins.ws      = ws_q;
    assign pins.sck     = sck_q;
    assign sample.valid = valid_q;
    assign sample.data  = data_q;

endmodule

// File: sample_processor.sv
module sample_processor
    import audio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mic_stream_t         mic,
    input  audio_ctrl_t         ctrl,
    input  logic                peak_clear,
    output sound_stream_t       sound,
    output logic [MIC_BITS-1:0] peak
);

    logic                         s1_valid;
    logic signed [PROD_W-1:0]     s1_prod;
    logic        [MIC_BITS-1:0]   s1_abs;
    logic signed [PROD_W-1:0]     scaled;
    logic signed [SOUND_BITS-1:0] clipped;
    logic                         s2_valid;
    logic signed [SOUND_BITS-1:0] s2_data;
    logic        [MIC_BITS-1:0]   peak_q;

    //------------------------------------------------
    // Stage one: gain multiply and magnitude

    always_ff @(posedge clk) begin
        if (mic.valid) begin
            s1_prod <= mic.data * $signed({1'b0, ctrl.gain});  // Gain is unsigned
            s1_abs  <= mic.data[MIC_BITS-1] ? MIC_BITS'(-mic.data) : mic.data;
        end
    end

    //------------------------------------------------
    // Stage two: shift, clip and mute

    assign scaled = s1_prod >>> GAIN_SHIFT;              // Floor division by 4096

    always_comb begin
        if (scaled > SOUND_MAX) begin
            clipped = SOUND_BITS'(SOUND_MAX);
        end else if (scaled < SOUND_MIN) begin
            clipped = SOUND_BITS'(SOUND_MIN);
        end else begin
            clipped = scaled[SOUND_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_data <= ctrl.mute ? '0 : clipped;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= mic.valid;
            s2_valid <= s1_valid;
        end
    end

    //------------------------------------------------
    // Peak level

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peak_q <= '0;
        end else if (peak_clear) begin
            peak_q <= s1_valid ? s1_abs : '0;            // Coincident sample starts the new window
        end else if (s1_valid && (s1_abs > peak_q)) begin
            peak_q <= s1_abs;
        end
    end

    assign sound.valid = s2_valid;
    assign sound.data  = s2_data;
    assign peak        = peak_q;

endmodule

// File: wb_audio_regs.sv
module wb_audio_regs
    import audio_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  wb_req_t             wb_req,
    output wb_rsp_t             wb_rsp,
    input  logic                mic_valid,
    input  logic [MIC_BITS-1:0] peak,
    output audio_ctrl_t         ctrl,
    output logic                peak_clear
);

    logic        req_new;
    logic        wr_ctrl;
    logic        ack_q;
    audio_ctrl_t ctrl_q;
    logic [31:0] frame_cnt;
    logic [31:0] rd_mux;

    //------------------------------------------------
    // Bus handshake

    // A held request is answered once, then the master drops stb
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ctrl = req_new && wb_req.we && (wb_req.addr == ADDR_CTRL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    //------------------------------------------------
    // Control and counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '{mute: 1'b0, gain: GAIN_RESET};
        end else if (wr_ctrl) begin
            ctrl_q <= audio_ctrl_t'(wb_req.wdata[8:0]);  // Visible in the ack cycle
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (mic_valid) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    //------------------------------------------------
    // Read path

    // Read data is taken live in the ack cycle, address is still held
    always_comb begin
        case (wb_req.addr)
            ADDR_CTRL:  rd_mux = {23'd0, ctrl_q};
            ADDR_PEAK:  rd_mux = {{(32 - MIC_BITS){1'b0}}, peak};
            ADDR_COUNT: rd_mux = frame_cnt;
            default:    rd_mux = '0;                     // Unmapped
        endcase
    end

    // Peak window restarts right after the value is returned
    assign peak_clear = ack_q && wb_req.cyc && wb_req.stb && !wb_req.we
                        && (wb_req.addr == ADDR_PEAK);

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.rdata = ack_q ? rd_mux : '0;
    assign ctrl         = ctrl_q;

endmodule

// File: i2s_audio_out.sv
module i2s_audio_out
    import audio_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  sound_stream_t sound,
    output i2s_out_pins_t pins
);

    logic                  mclk_q;
    logic [DIV_W-1:0]      div_cnt;
    logic                  div_tick;
    logic                  bclk_q;
    logic                  bclk_fall;
    logic [BIT_W-1:0]      bit_cnt;
    logic [BIT_W-1:0]      bit_next;
    logic                  lrclk_q;
    logic [SOUND_BITS-1:0] hold_q;
    logic [SOUND_BITS-1:0] shreg;
    logic                  sdata_q;

    //------------------------------------------------
    // Clocks

    assign div_tick  = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign bclk_fall = div_tick && bclk_q;
    assign bit_next  = (bit_cnt == BIT_W'(FRAME_BITS - 1)) ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mclk_q  <= 1'b0;
            div_cnt <= '0;
            bclk_q  <= 1'b0;
            bit_cnt <= '0;
            lrclk_q <= 1'b0;
        end else begin
            mclk_q <= ~mclk_q;                           // Half the system clock

            if (div_tick) begin
                div_cnt <= '0;
                bclk_q  <= ~bclk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (bclk_fall) begin
                bit_cnt <= bit_next;
                lrclk_q <= (bit_next >= BIT_W'(SLOT_BITS));
            end
        end
    end

    //------------------------------------------------
    // Sample holding and serializer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= '0;
        end else if (sound.valid) begin
            hold_q <= sound.data;                        // Newest sample wins
        end
    end

    // Zeros shift in behind the word, so the slot tail and the right slot stay low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg   <= '0;
            sdata_q <= 1'b0;
        end else if (bclk_fall) begin
            if (bit_next == '0) begin                    // lrclk falls, frame start
                shreg   <= sound.valid ? sound.data : hold_q;
                sdata_q <= 1'b0;
            end else begin
                shreg   <= {shreg[SOUND_BITS-2:0], 1'b0};
                sdata_q <= shreg[SOUND_BITS-1];          // MSB one bclk after frame start
            end
        end
    end

    assign pins.mclk  = mclk_q;
    assign pins.bclk  = bclk_q;
    assign pins.lrclk = lrclk_q;
    assign pins.sdata = sdata_q;

endmodule

// File: audio_lab_top.sv
module audio_lab_top
    import audio_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          mic_sd,
    output mic_pins_t     mic_pins,
    output i2s_out_pins_t i2s_pins,
    input  wb_req_t       wb_req,
    output wb_rsp_t       wb_rsp
);

    mic_stream_t         mic;
    sound_stream_t       sound;
    audio_ctrl_t         ctrl;
    logic [MIC_BITS-1:0] peak;
    logic                peak_clear;

    //------------------------------------------------
    // Microphone side

    i2s_mic_receiver i_mic_receiver
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sd         ( mic_sd     ),
        .pins       ( mic_pins   ),
        .sample     ( mic        )
    );

    //------------------------------------------------
    // Gain, clip, mute and peak

    sample_processor i_sample_processor
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .mic        ( mic        ),
        .ctrl       ( ctrl       ),
        .peak_clear ( peak_clear ),
        .sound      ( sound      ),
        .peak       ( peak       )
    );

    //------------------------------------------------
    // Register port

    wb_audio_regs i_wb_audio_regs
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .wb_req     ( wb_req     ),
        .wb_rsp     ( wb_rsp     ),
        .mic_valid  ( mic.valid  ),              // Frame counter input
        .peak       ( peak       ),
        .ctrl       ( ctrl       ),
        .peak_clear ( peak_clear )
    );

    //------------------------------------------------
    // Codec side

    i2s_audio_out i_audio_out
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sound      ( sound      ),
        .pins       ( i2s_pins   )
    );

endmodule

// File: tb_audio_lab.sv
module tb_audio_lab import audio_pkg::*; ();

    localparam int FRAME_CLKS = FRAME_BITS * 2 * BCLK_DIV;  // 512 clk cycles per frame
    localparam int POOL_SIZE  = 256;

    logic          clk;
    logic          rst_n;
    logic          mic_sd;
    mic_pins_t     mic_pins;
    i2s_out_pins_t i2s_pins;
    wb_req_t       wb_req;
    wb_rsp_t       wb_rsp;

    int                    sample_pool [POOL_SIZE];
    int                    mic_q [$];                 // Every sample sent by the mic model
    logic [SOUND_BITS-1:0] out_q [$];                 // Decoded left slot words
    int                    peak_mark;                 // mic_q size at the last PEAK read

    audio_lab_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model and compare tasks

    function automatic sound_stream_t expected_sound(int s, int gain, bit mute);
        longint        prod;
        sound_stream_t res;
        prod = (longint'(s) * gain) >>> GAIN_SHIFT;    // Floor toward minus infinity
        if (mute) prod = 0;
        else if (prod > SOUND_MAX) prod = SOUND_MAX;
        else if (prod < SOUND_MIN) prod = SOUND_MIN;
        res.valid = 1'b1;
        res.data  = prod[SOUND_BITS-1:0];
        return res;
    endfunction

    function automatic int abs_val(int s);
        return (s < 0) ? -s : s;
    endfunction

    task automatic abort_run(string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_sound(sound_stream_t got, sound_stream_t exp, string what);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                $time, what, got.data, exp.data));
    endtask

    // Accepts exp.rdata - slack up to exp.rdata
    task automatic check_wb(wb_rsp_t got, wb_rsp_t exp, int slack, string what);
        if (got.ack !== 1'b1 || $isunknown(got.rdata) || got.rdata > exp.rdata
            || longint'(got.rdata) + slack < longint'(exp.rdata))
            abort_run($sformatf("mismatch at %0t: %s read %0h expected %0h",
                                $time, what, got.rdata, exp.rdata));
    endtask

    task automatic check_peak(logic [MIC_BITS-1:0] got, logic [MIC_BITS-1:0] lo,
                              logic [MIC_BITS-1:0] hi, string what);
        if ($isunknown(got) || got < lo || got > hi)
            abort_run($sformatf("mismatch at %0t: %s peak %0d outside %0d to %0d",
                                $time, what, got, lo, hi));
    endtask

    // --------------------------------------------------
    // Bus and stream helpers

    task automatic wb_cycle(logic we, logic [3:0] addr, logic [31:0] wdata, output wb_rsp_t rsp);
        int t;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, wdata: wdata};
        t = 0;
        do begin
            @(posedge clk);
            #1;
            t++;
            if (t > 16) abort_run("Wishbone ack did not arrive within 16 cycles");
        end while (wb_rsp.ack !== 1'b1);
        rsp = wb_rsp;
        @(posedge clk);                                // Request held through the ack cycle
        #1;
        wb_req = '0;
    endtask

    task automatic wait_words(int n);
        int target;
        int t;
        target = out_q.size() + n;
        t = 0;
        while (out_q.size() < target) begin
            @(posedge clk);
            #1;
            t++;
            if (t > (n + 2) * FRAME_CLKS) abort_run("I2S output words stopped arriving");
        end
    endtask

    task automatic read_peak_window(string what);
        wb_rsp_t rsp;
        int      c;
        int      lo;
        int      hi;
        int      i;
        wb_cycle(1'b0, ADDR_PEAK, '0, rsp);
        c  = mic_q.size();
        lo = 0;
        hi = 0;
        for (i = (peak_mark > 0) ? peak_mark - 1 : 0; i < c; i++) begin
            if (abs_val(mic_q[i]) > hi) hi = abs_val(mic_q[i]);
            if (i >= peak_mark && i <= c - 2 && abs_val(mic_q[i]) > lo) lo = abs_val(mic_q[i]);
        end
        check_peak(rsp.rdata[MIC_BITS-1:0], MIC_BITS'(lo), MIC_BITS'(hi), what);
        peak_mark = c;
    endtask

    task automatic read_count();
        wb_rsp_t rsp;
        wb_rsp_t exp;
        wb_cycle(1'b0, ADDR_COUNT, '0, rsp);
        exp = '{ack: 1'b1, rdata: 32'(mic_q.size())};
        check_wb(rsp, exp, 1, "frame count");       // Newest sample may still be in flight
    endtask

    // Output words must follow the mic samples in order, repeats allowed
    task automatic run_gain_window(logic [7:0] gain, logic mute);
        wb_rsp_t       rsp;
        sound_stream_t got;
        int            m0;
        int            o0;
        int            j;
        int            k;
        wb_cycle(1'b1, ADDR_CTRL, {23'd0, mute, gain}, rsp);
        wait_words(3);                                 // Settling frames
        m0 = mic_q.size();
        o0 = out_q.size();
        wait_words(8);
        j   = (m0 >= 2) ? m0 - 2 : 0;
        got = '{valid: 1'b1, data: out_q[o0]};
        while (j < m0 && expected_sound(mic_q[j], gain, mute) !== got) j++;
        for (k = 0; k < 8; k++) begin
            got = '{valid: 1'b1, data: out_q[o0 + k]};
            if (j + 1 < mic_q.size() && got === expected_sound(mic_q[j + 1], gain, mute)) j++;
            check_sound(got, expected_sound(mic_q[j], gain, mute), "output word");
        end
    endtask

    // --------------------------------------------------
    // Microphone model that follows sck and ws

    initial begin
        int   cur;
        int   pos;
        int   idx;
        bit   started;
        logic prev_sck;
        logic prev_ws;
        mic_sd  = 1'b0;
        started = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                started = 1'b0;
                mic_sd  = 1'b0;
            end else if (!started) begin               // Reset leaves the mic at a left slot start
                cur     = sample_pool[0];
                idx     = 1;
                pos     = 0;
                started = 1'b1;
                mic_q.push_back(cur);
            end else if (prev_sck && !mic_pins.sck) begin
                if (prev_ws && !mic_pins.ws) begin     // ws fall starts a new frame
                    pos = 0;
                    cur = sample_pool[idx % POOL_SIZE];
                    idx++;
                    mic_q.push_back(cur);
                end else begin
                    pos++;
                end
                mic_sd = (pos >= 1 && pos <= MIC_BITS) ? cur[MIC_BITS - pos] : 1'b0;
            end
            prev_sck = mic_pins.sck;
            prev_ws  = mic_pins.ws;
        end
    end

    // --------------------------------------------------
    // I2S output decoder

    initial begin
        int                    opos;
        logic [SOUND_BITS-1:0] word;
        logic                  prev_bclk;
        logic                  prev_lr;
        logic                  prev_mclk;
        bit                    mclk_run;
        mclk_run = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                opos     = 0;
                word     = '0;
                mclk_run = 1'b0;
                if (i2s_pins.mclk !== 1'b0)
                    abort_run("mclk was not low during reset");
            end else begin
                if (mclk_run && (i2s_pins.mclk ^ prev_mclk) !== 1'b1)
                    abort_run("mclk did not toggle on every clk cycle");
                mclk_run = 1'b1;
                if (prev_bclk && !i2s_pins.bclk)
                    opos = (prev_lr && !i2s_pins.lrclk) ? 0 : opos + 1;
                if (!prev_bclk && i2s_pins.bclk) begin // Data is stable at rising bclk
                    if (opos >= 1 && opos <= SOUND_BITS) begin
                        word = {word[SOUND_BITS-2:0], i2s_pins.sdata};
                        if (opos == SOUND_BITS) out_q.push_back(word);
                    end else if (i2s_pins.sdata !== 1'b0) begin
                        abort_run("sdata was not zero outside the left sample bits");
                    end
                end
            end
            prev_bclk = i2s_pins.bclk;
            prev_lr   = i2s_pins.lrclk;
            prev_mclk = i2s_pins.mclk;
        end
    end

    // --------------------------------------------------
    // Main sequence

    initial begin
        wb_rsp_t     rsp;
        wb_rsp_t     exp;
        logic [31:0] r;
        int          i;
        rst_n     = 1'b0;
        wb_req    = '0;
        peak_mark = 0;
        void'($urandom(32'he3c8_f47b));
        for (i = 0; i < POOL_SIZE; i++) begin
            r = $urandom;
            case (r[2:0])
                3'd0:    sample_pool[i] = 8388607;     // Full scale positive
                3'd1:    sample_pool[i] = -8388608;    // Full scale negative
                default: sample_pool[i] = int'($signed(r[31:8]));
            endcase
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        for (i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            if ({mic_pins.ws, i2s_pins.lrclk, i2s_pins.sdata} !== 3'b000)
                abort_run("ws, lrclk or sdata left low state after reset");
        end
        wb_cycle(1'b0, ADDR_CTRL, '0, rsp);
        exp = '{ack: 1'b1, rdata: {23'd0, 1'b0, GAIN_RESET}};
        check_wb(rsp, exp, 0, "CTRL after reset");
        wb_cycle(1'b0, ADDR_PEAK, '0, rsp);
        check_peak(rsp.rdata[MIC_BITS-1:0], '0, '0, "PEAK after reset");
        peak_mark = mic_q.size();
        wb_cycle(1'b0, ADDR_COUNT, '0, rsp);
        exp = '{ack: 1'b1, rdata: 32'd0};
        check_wb(rsp, exp, 0, "COUNT after reset");

        // Register access
        for (i = 0; i < 6; i++) begin
            r = $urandom;
            wb_cycle(1'b1, ADDR_CTRL, r, rsp);
            wb_cycle(1'b0, ADDR_CTRL, '0, rsp);
            exp = '{ack: 1'b1, rdata: r & 32'h1ff};
            check_wb(rsp, exp, 0, "CTRL readback");
        end
        wait_words(3);                                 // Peak and count are nonzero by now
        wb_cycle(1'b1, ADDR_PEAK, $urandom, rsp);
        read_peak_window("PEAK after write");
        wb_cycle(1'b1, ADDR_COUNT, $urandom, rsp);
        read_count();
        wb_cycle(1'b0, 4'(3 + $urandom_range(12)), '0, rsp);
        exp = '{ack: 1'b1, rdata: 32'd0};
        check_wb(rsp, exp, 0, "unmapped address");

        // Gain, saturation and mute
        run_gain_window(8'd0, 1'b0);
        run_gain_window(8'd255, 1'b0);
        for (i = 0; i < 3; i++) run_gain_window(8'($urandom), 1'b0);
        run_gain_window(8'($urandom), 1'b1);
        run_gain_window(GAIN_RESET, 1'b0);

        // Peak and count
        read_peak_window("PEAK window");
        read_peak_window("PEAK second read");
        wait_words(3);
        read_peak_window("PEAK window");
        read_count();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb.f
audio_pkg.sv
i2s_mic_receiver.sv
sample_processor.sv
wb_audio_regs.sv
i2s_audio_out.sv
audio_lab_top.sv
tb_audio_lab.sv

// File: Bender.yml
package:
  name: audio_lab

sources:
  - audio_pkg.sv
  - i2s_mic_receiver.sv
  - sample_processor.sv
  - wb_audio_regs.sv
  - i2s_audio_out.sv
  - audio_lab_top.sv
  - target: test
    files:
      - tb_audio_lab.sv
